// File: logic/cpu_types_pkg.sv
package cpu_types_pkg;

	// datapath widths
	localparam int WORD_W = 32;
	localparam int REG_W = 5;
	localparam int IMM_W = 16;
	localparam int NUM_REGS = 32;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_W-1:0] regbits_t;

	// alu operations
	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLT,
		OP_LUI
	} alu_op_t;

	// decoded instruction from the issuer
	typedef struct packed {
		logic valid;
		alu_op_t op;
		regbits_t rs;
		regbits_t rt;
		regbits_t rd;
		logic [IMM_W-1:0] imm16;
		logic use_imm;
		logic mem_read;
		logic mem_write;
		logic wen;
		logic halt;
	} issue_t;

	// execute to memory
	typedef struct packed {
		logic valid;
		logic wen;
		regbits_t rd;
		word_t result;
		word_t store_data;
		logic mem_read;
		logic mem_write;
		logic halt;
	} ex_mem_t;

	// memory to writeback
	typedef struct packed {
		logic valid;
		logic wen;
		regbits_t rd;
		word_t result;
		word_t load_data;
		logic mem_read;
		logic halt;
	} mem_wb_t;

	// register file write port, also visible at the top
	typedef struct packed {
		logic wen;
		regbits_t rd;
		word_t wdata;
		logic halt;
	} wb_t;

endpackage

// File: logic/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
	input cpu_types_pkg::issue_t issue,
	input cpu_types_pkg::ex_mem_t ex_mem,
	input cpu_types_pkg::mem_wb_t mem_wb,
	input cpu_types_pkg::word_t rdat1,
	input cpu_types_pkg::word_t rdat2,
	output cpu_types_pkg::regbits_t rsel1,
	output cpu_types_pkg::regbits_t rsel2,
	output cpu_types_pkg::ex_mem_t out
);

	import cpu_types_pkg::*;

	word_t op_a;
	word_t rt_val;
	word_t op_b;
	word_t imm_ext;
	word_t result;

	// operand with forwarding, nearest producer wins
	function automatic word_t operand(input regbits_t sel, input word_t rf_val);
		word_t val;
		if (sel == '0) begin
			val = '0;
		end
		else if (ex_mem.valid && ex_mem.wen && (ex_mem.rd == sel)) begin
			val = ex_mem.result;
		end
		else if (mem_wb.valid && mem_wb.wen && (mem_wb.rd == sel)) begin
			val = mem_wb.mem_read ? mem_wb.load_data : mem_wb.result;
		end
		else begin
			val = rf_val;
		end
		return val;
	endfunction

	assign rsel1 = issue.rs;
	assign rsel2 = issue.rt;

	assign imm_ext = {{(WORD_W-IMM_W){issue.imm16[IMM_W-1]}}, issue.imm16};

	always_comb begin
		op_a = operand(issue.rs, rdat1);
		rt_val = operand(issue.rt, rdat2);
	end

	assign op_b = issue.use_imm ? imm_ext : rt_val;

	always_comb begin
		case (issue.op)
			OP_ADD: result = op_a + op_b;
			OP_SUB: result = op_a - op_b;
			OP_AND: result = op_a & op_b;
			OP_OR: result = op_a | op_b;
			OP_XOR: result = op_a ^ op_b;
			OP_SLT: result = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
			// upper half from the raw immediate
			OP_LUI: result = {issue.imm16, {(WORD_W-IMM_W){1'b0}}};
			default: result = '0;
		endcase
	end

	// result doubles as the address for loads and stores
	always_comb begin
		out.valid = issue.valid;
		out.wen = issue.wen;
		out.rd = issue.rd;
		out.result = result;
		out.store_data = rt_val;
		out.mem_read = issue.mem_read;
		out.mem_write = issue.mem_write;
		out.halt = issue.halt;
	end

	// issuer never sends a combined load and store
	always_comb begin
		if (issue.valid) begin
			assert (!(issue.mem_read && issue.mem_write))
				else $error("execute_stage: load and store on one issue");
		end
	end

endmodule

// File: logic/pipe_reg.sv
`timescale 1ns/10ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input logic CLK,
	input logic nRST,
	input logic enable,
	input logic flush,
	input payload_t d,
	output payload_t q
);

	payload_t q_reg;

	assign q = q_reg;

	// flush beats enable, so a flushed slot is a bubble even under hold
	always_ff @(posedge CLK, negedge nRST) begin
		if (nRST == 1'b0) begin
			q_reg <= '0;
		end
		else if (flush) begin
			q_reg <= '0;
		end
		else if (enable) begin
			q_reg <= d;
		end
	end

	// a flushed stage must read as all zeros on the next cycle
	property p_flush_clears;
		@(posedge CLK) disable iff (!nRST)
		flush |=> (q == '0);
	endproperty

	a_flush_clears: assert property (p_flush_clears)
		else $error("pipe_reg: q not cleared after flush");

endmodule

// File: logic/mem_stage.sv
`timescale 1ns/10ps

module mem_stage #(
	parameter int DMEM_WORDS = 64
) (
	input logic CLK,
	input logic nRST,
	input cpu_types_pkg::ex_mem_t in,
	output cpu_types_pkg::mem_wb_t out
);

	import cpu_types_pkg::*;

	localparam int IDX_W = $clog2(DMEM_WORDS);

	word_t dmem [DMEM_WORDS];
	logic [IDX_W-1:0] idx;

	// word index, wraps at the memory size
	assign idx = IDX_W'((in.result >> 2) % DMEM_WORDS);

	// memory reads zero after reset
	always_ff @(posedge CLK, negedge nRST) begin
		if (nRST == 1'b0) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end
		else if (in.valid && in.mem_write) begin
			dmem[idx] <= in.store_data;
		end
	end

	// load data is combinational
	always_comb begin
		out.valid = in.valid;
		out.wen = in.wen;
		out.rd = in.rd;
		out.result = in.result;
		out.load_data = dmem[idx];
		out.mem_read = in.mem_read;
		out.halt = in.halt;
	end

	property p_word_aligned;
		@(posedge CLK) disable iff (!nRST)
		(in.valid && (in.mem_read || in.mem_write)) |-> (in.result[1:0] == 2'b00);
	endproperty

	a_word_aligned: assert property (p_word_aligned)
		else $error("mem_stage: unaligned access at %h", in.result);

endmodule

// File: logic/writeback_rf.sv
`timescale 1ns/10ps

module writeback_rf (
	input logic CLK,
	input logic nRST,
	input cpu_types_pkg::mem_wb_t in,
	input cpu_types_pkg::regbits_t rsel1,
	input cpu_types_pkg::regbits_t rsel2,
	output cpu_types_pkg::word_t rdat1,
	output cpu_types_pkg::word_t rdat2,
	output cpu_types_pkg::wb_t wb,
	output logic halted
);

	import cpu_types_pkg::*;

	word_t regs [NUM_REGS];
	logic halted_reg;

	// bubbles never write and never halt
	always_comb begin
		wb.wen = in.valid & in.wen;
		wb.rd = in.rd;
		wb.wdata = in.mem_read ? in.load_data : in.result;
		wb.halt = in.valid & in.halt;
	end

	// register 0 is never written so it stays zero
	always_ff @(posedge CLK, negedge nRST) begin
		if (nRST == 1'b0) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end
		else if (wb.wen && (wb.rd != '0)) begin
			regs[wb.rd] <= wb.wdata;
		end
	end

	assign rdat1 = regs[rsel1];
	assign rdat2 = regs[rsel2];

	// sticky until reset
	always_ff @(posedge CLK, negedge nRST) begin
		if (nRST == 1'b0) begin
			halted_reg <= 1'b0;
		end
		else if (wb.halt) begin
			halted_reg <= 1'b1;
		end
	end

	assign halted = halted_reg;

endmodule

// File: logic/backend_top.sv
`timescale 1ns/10ps

module backend_top #(
	parameter int DMEM_WORDS = 64
) (
	input logic CLK,
	input logic nRST,
	input cpu_types_pkg::issue_t issue,
	input logic hold,
	input logic flush,
	output cpu_types_pkg::wb_t wb,
	output logic halted
);

	import cpu_types_pkg::*;

	ex_mem_t ex_mem_d;
	ex_mem_t ex_mem_q;
	mem_wb_t mem_wb_d;
	mem_wb_t mem_wb_q;
	regbits_t rsel1;
	regbits_t rsel2;
	word_t rdat1;
	word_t rdat2;
	logic advance;

	// hold freezes both stages
	assign advance = !hold;

	execute_stage i_execute (
		.issue(issue),
		.ex_mem(ex_mem_q),
		.mem_wb(mem_wb_q),
		.rdat1(rdat1),
		.rdat2(rdat2),
		.rsel1(rsel1),
		.rsel2(rsel2),
		.out(ex_mem_d)
	);

	// flush squashes only what is in execute
	pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
		.CLK(CLK),
		.nRST(nRST),
		.enable(advance),
		.flush(flush),
		.d(ex_mem_d),
		.q(ex_mem_q)
	);

	mem_stage #(.DMEM_WORDS(DMEM_WORDS)) i_mem (
		.CLK(CLK),
		.nRST(nRST),
		.in(ex_mem_q),
		.out(mem_wb_d)
	);

	pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
		.CLK(CLK),
		.nRST(nRST),
		.enable(advance),
		.flush(1'b0),
		.d(mem_wb_d),
		.q(mem_wb_q)
	);

	writeback_rf i_wb (
		.CLK(CLK),
		.nRST(nRST),
		.in(mem_wb_q),
		.rsel1(rsel1),
		.rsel2(rsel2),
		.rdat1(rdat1),
		.rdat2(rdat2),
		.wb(wb),
		.halted(halted)
	);

endmodule

// File: test/backend_tb.sv
`timescale 1ns/10ps

module backend_tb;

	import cpu_types_pkg::*;

	localparam int DMEM_WORDS = 64;
	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 3;
	localparam int ROUNDS = 4;
	// reset, register sweep, alu rounds, load/store, flush, hold, halt
	localparam int TEST_CYCLES = RESET_CYCLES + 34 + ROUNDS * 16 + 10 + 5 + 9 + 6;
	localparam int MARGIN_CYCLES = 50;

	logic CLK;
	logic nRST;
	issue_t issue;
	logic hold;
	logic flush;
	wb_t wb;
	logic halted;

	// reference model state, updated in program order
	word_t ref_regs [NUM_REGS];
	word_t ref_mem [DMEM_WORDS];
	logic ref_halted;
	wb_t exp_ex;
	wb_t exp_wb;

	int wb_errors;
	int bit_errors;
	integer seed;

	backend_top #(.DMEM_WORDS(DMEM_WORDS)) i_dut (
		.CLK(CLK),
		.nRST(nRST),
		.issue(issue),
		.hold(hold),
		.flush(flush),
		.wb(wb),
		.halted(halted)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		#(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
		$display("watchdog expired before the tests completed");
		$display("TEST FAILED");
		$finish;
	end

	function automatic issue_t alu_rr(alu_op_t op, regbits_t rd, regbits_t rs, regbits_t rt);
		issue_t ins;
		ins = '0;
		ins.valid = 1'b1;
		ins.op = op;
		ins.rd = rd;
		ins.rs = rs;
		ins.rt = rt;
		ins.wen = 1'b1;
		return ins;
	endfunction

	function automatic issue_t alu_ri(alu_op_t op, regbits_t rd, regbits_t rs, logic [15:0] imm);
		issue_t ins;
		ins = alu_rr(op, rd, rs, 5'd0);
		ins.imm16 = imm;
		ins.use_imm = 1'b1;
		return ins;
	endfunction

	function automatic issue_t load_word(regbits_t rd, regbits_t rs, logic [15:0] imm);
		issue_t ins;
		ins = alu_ri(OP_ADD, rd, rs, imm);
		ins.mem_read = 1'b1;
		return ins;
	endfunction

	function automatic issue_t store_word(regbits_t rt, regbits_t rs, logic [15:0] imm);
		issue_t ins;
		ins = alu_ri(OP_ADD, 5'd0, rs, imm);
		ins.rt = rt;
		ins.wen = 1'b0;
		ins.mem_write = 1'b1;
		return ins;
	endfunction

	function automatic issue_t halt_instr();
		issue_t ins;
		ins = '0;
		ins.valid = 1'b1;
		ins.halt = 1'b1;
		return ins;
	endfunction

	// architectural result of one valid instruction
	task automatic predict(input issue_t ins, output wb_t exp);
		word_t a;
		word_t rt_val;
		word_t b;
		word_t res;
		word_t wdata;
		int idx;
		a = ref_regs[ins.rs];
		rt_val = ref_regs[ins.rt];
		b = ins.use_imm ? {{16{ins.imm16[15]}}, ins.imm16} : rt_val;
		case (ins.op)
			OP_ADD: res = a + b;
			OP_SUB: res = a - b;
			OP_AND: res = a & b;
			OP_OR: res = a | b;
			OP_XOR: res = a ^ b;
			OP_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OP_LUI: res = {ins.imm16, 16'h0000};
			default: res = '0;
		endcase
		idx = int'(res >> 2) % DMEM_WORDS;
		if (ins.mem_write) begin
			ref_mem[idx] = rt_val;
		end
		wdata = ins.mem_read ? ref_mem[idx] : res;
		if (ins.wen && (ins.rd != 5'd0)) begin
			ref_regs[ins.rd] = wdata;
		end
		exp = '0;
		exp.wen = ins.wen;
		exp.rd = ins.rd;
		exp.wdata = wdata;
		exp.halt = ins.halt;
	endtask

	// wdata and rd only matter when the port writes
	task automatic check_wb(input wb_t got, input wb_t exp, input string name);
		logic bad;
		if (exp.wen) begin
			bad = (got !== exp);
		end
		else begin
			bad = (got.wen !== 1'b0) || (got.halt !== exp.halt);
		end
		if (bad) begin
			wb_errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			bit_errors++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// one cycle: check outputs, drive inputs, advance the model past the next edge
	task automatic step(input issue_t ins, input logic do_flush, input logic do_hold);
		wb_t predicted;
		@(negedge CLK);
		check_wb(wb, exp_wb, "wb");
		check_bit(halted, ref_halted, "halted");
		issue = ins;
		flush = do_flush;
		hold = do_hold;
		if (exp_wb.halt) begin
			ref_halted = 1'b1;
		end
		if (!do_hold) begin
			exp_wb = exp_ex;
			if (do_flush || !ins.valid) begin
				exp_ex = '0;
			end
			else begin
				predict(ins, predicted);
				exp_ex = predicted;
			end
		end
	endtask

	task automatic send(input issue_t ins);
		step(ins, 1'b0, 1'b0);
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) send('0);
	endtask

	// low half is sign extended, the model follows it
	task automatic load_value(input regbits_t rd, input word_t val);
		send(alu_ri(OP_LUI, rd, 5'd0, val[31:16]));
		send(alu_ri(OP_OR, rd, rd, val[15:0]));
	endtask

	task automatic test_reset_state();
		for (int r = 0; r < NUM_REGS; r++) begin
			send(alu_rr(OP_OR, regbits_t'(r), regbits_t'(r), 5'd0));
		end
		idle(2);
	endtask

	// each op uses the two previous results
	task automatic test_alu_chain();
		for (int n = 0; n < ROUNDS; n++) begin
			for (int r = 1; r <= 4; r++) begin
				load_value(regbits_t'(r), $random(seed));
			end
			send(alu_rr(OP_ADD, 5'd5, 5'd1, 5'd2));
			send(alu_rr(OP_SUB, 5'd6, 5'd5, 5'd3));
			send(alu_rr(OP_AND, 5'd7, 5'd6, 5'd5));
			send(alu_rr(OP_OR, 5'd8, 5'd7, 5'd4));
			send(alu_rr(OP_XOR, 5'd9, 5'd8, 5'd7));
			send(alu_rr(OP_SLT, 5'd10, 5'd9, 5'd8));
			send(alu_ri(OP_SLT, 5'd11, 5'd9, 16'h8000));
			send(alu_ri(OP_ADD, 5'd12, 5'd10, 16'hfff0));
		end
	endtask

	task automatic test_load_store();
		load_value(5'd20, $random(seed));
		send(store_word(5'd20, 5'd0, 16'h0010));
		send(load_word(5'd21, 5'd0, 16'h0010));
		// load target not used in the next cycle
		idle(1);
		send(alu_rr(OP_ADD, 5'd22, 5'd21, 5'd0));
		send(alu_rr(OP_ADD, 5'd0, 5'd20, 5'd20));
		send(alu_rr(OP_OR, 5'd23, 5'd0, 5'd22));
		idle(2);
	endtask

	task automatic test_flush();
		send(alu_ri(OP_ADD, 5'd24, 5'd0, 16'h0055));
		step(alu_ri(OP_ADD, 5'd24, 5'd0, 16'h0aaa), 1'b1, 1'b0);
		send(alu_ri(OP_ADD, 5'd25, 5'd24, 16'h0001));
		idle(2);
	endtask

	// the instruction offered under hold must be dropped
	task automatic test_hold();
		send(alu_ri(OP_ADD, 5'd26, 5'd0, 16'h0007));
		send(alu_ri(OP_ADD, 5'd27, 5'd26, 16'h0001));
		repeat (3) step(alu_ri(OP_ADD, 5'd26, 5'd0, 16'h0063), 1'b0, 1'b1);
		send(alu_rr(OP_ADD, 5'd28, 5'd27, 5'd26));
		send(alu_rr(OP_SUB, 5'd29, 5'd28, 5'd27));
		idle(2);
	endtask

	task automatic test_halt();
		send(halt_instr());
		idle(5);
	endtask

	initial begin
		seed = 32'h388e;
		nRST = 1'b0;
		issue = '0;
		hold = 1'b0;
		flush = 1'b0;
		wb_errors = 0;
		bit_errors = 0;
		ref_halted = 1'b0;
		exp_ex = '0;
		exp_wb = '0;
		for (int i = 0; i < NUM_REGS; i++) begin
			ref_regs[i] = '0;
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			ref_mem[i] = '0;
		end
		repeat (RESET_CYCLES) @(negedge CLK);
		nRST = 1'b1;
		test_reset_state();
		test_alu_chain();
		test_load_store();
		test_flush();
		test_hold();
		test_halt();
		$display("errors: wb %0d, halted %0d", wb_errors, bit_errors);
		if ((wb_errors == 0) && (bit_errors == 0)) begin
			$display("TEST OK");
		end
		else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
logic/cpu_types_pkg.sv
logic/execute_stage.sv
logic/pipe_reg.sv
logic/mem_stage.sv
logic/writeback_rf.sv
logic/backend_top.sv
test/backend_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= backend_tb
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)
